// File: logic/exe_settings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// Datapath word width
`define EXE_XLEN 32

// Register file address width
`define EXE_REG_ADDR_W 5

// Iterations of the multiply and divide loops, one result bit each
`define EXE_MC_STEPS 32

// Address misalignment exception code
`define EXE_ECODE_ALE 6'h09

`endif

// File: logic/exe_op_pkg.sv
`include "exe_settings.svh"

package exe_op_pkg;

    // Execute operation code
    typedef enum logic [4:0] {
        ADD     = 5'd0,
        SUB     = 5'd1,
        SLT     = 5'd2,
        SLTU    = 5'd3,
        AND     = 5'd4,
        OR      = 5'd5,
        NOR     = 5'd6,
        XOR     = 5'd7,
        SLL     = 5'd8,
        SRL     = 5'd9,
        SRA     = 5'd10,
        LUI     = 5'd11,
        MUL     = 5'd12,  // Low word of product
        MULH    = 5'd13,
        MULHU   = 5'd14,
        DIV     = 5'd15,
        MOD     = 5'd16,
        DIVU    = 5'd17,
        MODU    = 5'd18,
        RDCNTVL = 5'd19,  // Stable counter halves
        RDCNTVH = 5'd20
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        LD_B     = 4'd1,
        LD_H     = 4'd2,
        LD_W     = 4'd3,
        LD_BU    = 4'd4,
        LD_HU    = 4'd5,
        ST_B     = 4'd6,
        ST_H     = 4'd7,
        ST_W     = 4'd8
    } mem_op_e;

    // Sized by the ALE code literal
    typedef logic [$bits(`EXE_ECODE_ALE)-1:0] ecode_t;

endpackage

// File: logic/exe_data_pkg.sv
`include "exe_settings.svh"

package exe_data_pkg;

    // One architectural register value
    typedef logic [`EXE_XLEN-1:0] word_t;

    // Full product and stable counter
    typedef logic [2*`EXE_XLEN-1:0] dword_t;

    typedef logic [`EXE_REG_ADDR_W-1:0] reg_addr_t;

    // One enable per byte lane
    typedef logic [`EXE_XLEN/8-1:0] strobe_t;

    // Multiply/divide sequencing
    typedef enum logic [1:0] {
        MC_IDLE = 2'd0,
        MC_RUN  = 2'd1,
        MC_DONE = 2'd2
    } mc_state_e;

endpackage

// File: logic/mem_access_decode.sv
`timescale 1ns/1ns

module mem_access_decode
    import exe_op_pkg::*, exe_data_pkg::*;
(
    input  mem_op_e mem_op,
    input  word_t   addr,
    input  word_t   store_data,
    output logic    is_access,
    output logic    is_store,
    output logic    misaligned,
    output strobe_t wstrb,
    output word_t   wdata
);

    logic       is_half;
    logic       is_word;
    logic [1:0] lane;

    assign lane = addr[1:0];

    assign is_access = (mem_op != MEM_NONE);
    assign is_store  = mem_op inside {ST_B, ST_H, ST_W};
    assign is_half   = mem_op inside {LD_H, LD_HU, ST_H};
    assign is_word   = mem_op inside {LD_W, ST_W};

    // Halfwords need even addresses, words need a multiple of four
    assign misaligned = (is_half & lane[0]) | (is_word & (|lane));

    always_comb begin
        wstrb = '0;
        wdata = '0;
        if (!misaligned) begin
            case (mem_op)
                ST_B: begin
                    wstrb = strobe_t'(1) << lane;
                    wdata = word_t'(store_data[7:0]) << {lane, 3'b000};
                end
                ST_H: begin
                    // Upper or lower half of the word
                    if (lane[1]) begin
                        wstrb = 4'b1100;
                        wdata = {store_data[15:0], 16'h0000};
                    end else begin
                        wstrb = 4'b0011;
                        wdata = {16'h0000, store_data[15:0]};
                    end
                end
                ST_W: begin
                    wstrb = '1;
                    wdata = store_data;
                end
                default: begin  // Loads write nothing
                    wstrb = '0;
                    wdata = '0;
                end
            endcase
        end
    end

endmodule

// File: logic/exe_alu.sv
`timescale 1ns/1ns

module exe_alu
    import exe_op_pkg::*, exe_data_pkg::*;
(
    input  alu_op_e alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ADD: begin
                result = src1 + src2;
            end
            SUB: begin
                result = src1 - src2;
            end
            SLT: begin
                result = word_t'($signed(src1) < $signed(src2));
            end
            SLTU: begin
                result = word_t'(src1 < src2);
            end
            AND: begin
                result = src1 & src2;
            end
            OR: begin
                result = src1 | src2;
            end
            NOR: begin
                result = ~(src1 | src2);
            end
            XOR: begin
                result = src1 ^ src2;
            end
            SLL: begin
                result = src1 << shamt;
            end
            SRL: begin
                result = src1 >> shamt;
            end
            SRA: begin
                result = word_t'($signed(src1) >>> shamt);  // Sign fill
            end
            LUI: begin
                result = src2;  // Immediate already shifted by decode
            end
            default: begin  // Multi-cycle and counter ops select elsewhere
                result = '0;
            end
        endcase
    end

endmodule

// File: logic/muldiv_unit.sv
`timescale 1ns/1ns
`include "exe_settings.svh"

module muldiv_unit
    import exe_op_pkg::*, exe_data_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    start,
    input  alu_op_e alu_op,
    input  word_t   op_a,
    input  word_t   op_b,
    output logic    busy,
    output logic    done,
    output dword_t  product,
    output word_t   quotient,
    output word_t   remainder
);

    localparam int CNT_W = $clog2(`EXE_MC_STEPS);

    mc_state_e            state;
    logic [CNT_W-1:0]     step;
    logic                 load;
    logic                 signed_op;
    logic                 op_is_div;
    word_t                mag_a;
    word_t                mag_b;
    logic                 is_div;
    logic                 neg_main;   // Product or quotient negative
    logic                 neg_rem;    // Remainder follows the dividend
    logic                 div_zero;
    word_t                hi;         // Partial product or remainder
    word_t                lo;         // Multiplier or dividend/quotient bits
    word_t                operand;    // Multiplicand or divisor
    logic [`EXE_XLEN:0]   mul_sum;
    logic [`EXE_XLEN:0]   div_shift;
    logic [`EXE_XLEN+1:0] div_diff;
    dword_t               mag_prod;

    assign busy = (state == MC_RUN);
    assign done = (state == MC_DONE);
    assign load = start & ~busy;

    assign signed_op = alu_op inside {MUL, MULH, DIV, MOD};
    assign op_is_div = alu_op inside {DIV, MOD, DIVU, MODU};
    assign mag_a     = (signed_op & op_a[`EXE_XLEN-1]) ? -op_a : op_a;
    assign mag_b     = (signed_op & op_b[`EXE_XLEN-1]) ? -op_b : op_b;

    // One shift-add step
    assign mul_sum = {1'b0, hi} + (lo[0] ? {1'b0, operand} : '0);

    // One restoring divide step, borrow in the top bit
    assign div_shift = {hi, lo[`EXE_XLEN-1]};
    assign div_diff  = {1'b0, div_shift} - {2'b00, operand};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= MC_IDLE;
            step  <= '0;
        end else if (load) begin
            state <= MC_RUN;
            step  <= '0;
        end else if (state == MC_RUN) begin
            if (step == CNT_W'(`EXE_MC_STEPS - 1)) begin
                state <= MC_DONE;
            end else begin
                step <= step + 1'b1;
            end
        end else begin
            state <= MC_IDLE;  // Done lasts one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            is_div   <= op_is_div;
            neg_main <= signed_op & (op_a[`EXE_XLEN-1] ^ op_b[`EXE_XLEN-1]);
            neg_rem  <= signed_op & op_a[`EXE_XLEN-1];
            div_zero <= (op_b == '0);
            hi       <= '0;
            lo       <= mag_a;
            operand  <= mag_b;
        end else if (busy) begin
            if (is_div) begin
                hi <= div_diff[`EXE_XLEN+1] ? div_shift[`EXE_XLEN-1:0] : div_diff[`EXE_XLEN-1:0];
                lo <= {lo[`EXE_XLEN-2:0], ~div_diff[`EXE_XLEN+1]};
            end else begin
                hi <= mul_sum[`EXE_XLEN:1];
                lo <= {mul_sum[0], lo[`EXE_XLEN-1:1]};
            end
        end
    end

    // Sign fix on held magnitudes, stable until the next start
    assign mag_prod  = {hi, lo};
    assign product   = neg_main ? -mag_prod : mag_prod;
    assign quotient  = div_zero ? '1 : (neg_main ? -lo : lo);
    assign remainder = neg_rem ? -hi : hi;  // Equals the dividend when dividing by zero

endmodule

// File: logic/result_select.sv
`timescale 1ns/1ns

module result_select
    import exe_op_pkg::*, exe_data_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  alu_op_e alu_op,
    input  word_t   alu_result,
    input  dword_t  product,
    input  word_t   quotient,
    input  word_t   remainder,
    output word_t   result
);

    dword_t stable_cnt;

    // Free-running, zero in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    always_comb begin
        case (alu_op)
            MUL:         result = product[31:0];
            MULH, MULHU: result = product[63:32];  // Sign already fixed in the unit
            DIV, DIVU:   result = quotient;
            MOD, MODU:   result = remainder;
            RDCNTVL:     result = stable_cnt[31:0];
            RDCNTVH:     result = stable_cnt[63:32];
            default:     result = alu_result;
        endcase
    end

endmodule

// File: logic/exe_stage.sv
`timescale 1ns/1ns
`include "exe_settings.svh"

module exe_stage
    import exe_op_pkg::*, exe_data_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      id_to_exe_valid,
    input  alu_op_e   id_alu_op,
    input  mem_op_e   id_mem_op,
    input  word_t     id_src1,
    input  word_t     id_src2,
    input  word_t     id_rkd_value,
    input  logic      id_rf_we,
    input  reg_addr_t id_rf_waddr,
    input  word_t     id_pc,
    input  logic      mem_allowin,
    input  logic      data_addr_ok,
    output logic      exe_allowin,
    output logic      exe_to_mem_valid,
    output word_t     mem_result,
    output logic      mem_rf_we,
    output reg_addr_t mem_rf_waddr,
    output word_t     mem_pc,
    output mem_op_e   mem_mem_op,
    output logic      mem_ex_valid,
    output ecode_t    mem_ecode,
    output word_t     mem_badv,
    output logic      data_valid,
    output logic      data_op,
    output word_t     data_addr,
    output strobe_t   data_wstrb,
    output word_t     data_wdata
);

    logic      exe_valid;
    alu_op_e   exe_alu_op;
    mem_op_e   exe_mem_op;
    word_t     exe_src1;
    word_t     exe_src2;
    word_t     exe_rkd_value;
    logic      exe_rf_we;
    reg_addr_t exe_rf_waddr;
    word_t     exe_pc;
    logic      accept;
    logic      id_is_mc;
    logic      exe_is_mc;
    logic      mc_start;     // One cycle after acceptance
    logic      mc_finished;  // Set by done, held under back-pressure
    logic      mc_busy;
    logic      mc_done;
    dword_t    mc_product;
    word_t     mc_quotient;
    word_t     mc_remainder;
    word_t     alu_result;
    word_t     final_result;
    word_t     mem_addr;
    logic      is_access;
    logic      is_store;
    logic      misaligned;
    logic      mem_req;
    logic      ready_go;

    assign accept    = id_to_exe_valid & exe_allowin;
    assign id_is_mc  = id_alu_op inside {MUL, MULH, MULHU, DIV, MOD, DIVU, MODU};
    assign exe_is_mc = exe_alu_op inside {MUL, MULH, MULHU, DIV, MOD, DIVU, MODU};
    assign mem_addr  = exe_src1 + exe_src2;  // Base plus offset, untranslated

    // Faulting accesses never reach the cache
    assign mem_req    = exe_valid & is_access & ~misaligned;
    assign data_valid = mem_req & mem_allowin;

    always_comb begin
        if (exe_is_mc) begin
            ready_go = mc_finished & ~mc_busy;
        end else if (mem_req) begin
            ready_go = data_valid & data_addr_ok;
        end else begin
            ready_go = 1'b1;
        end
    end

    assign exe_allowin      = ~exe_valid | (ready_go & mem_allowin);
    assign exe_to_mem_valid = exe_valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_valid   <= 1'b0;
            mc_start    <= 1'b0;
            mc_finished <= 1'b0;
        end else begin
            if (exe_allowin) begin
                exe_valid <= id_to_exe_valid;
            end
            mc_start <= accept & id_is_mc;
            if (accept) begin
                mc_finished <= 1'b0;
            end else if (mc_done) begin
                mc_finished <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exe_alu_op    <= id_alu_op;
            exe_mem_op    <= id_mem_op;
            exe_src1      <= id_src1;
            exe_src2      <= id_src2;
            exe_rkd_value <= id_rkd_value;
            exe_rf_we     <= id_rf_we;
            exe_rf_waddr  <= id_rf_waddr;
            exe_pc        <= id_pc;
        end
    end

    exe_alu u_alu (
        .alu_op (exe_alu_op),
        .src1   (exe_src1),
        .src2   (exe_src2),
        .result (alu_result)
    );

    mem_access_decode u_mem_dec (
        .mem_op     (exe_mem_op),
        .addr       (mem_addr),
        .store_data (exe_rkd_value),
        .is_access  (is_access),
        .is_store   (is_store),
        .misaligned (misaligned),
        .wstrb      (data_wstrb),
        .wdata      (data_wdata)
    );

    muldiv_unit u_muldiv (
        .clk       (clk),
        .resetn    (resetn),
        .start     (mc_start),
        .alu_op    (exe_alu_op),
        .op_a      (exe_src1),
        .op_b      (exe_src2),
        .busy      (mc_busy),
        .done      (mc_done),
        .product   (mc_product),
        .quotient  (mc_quotient),
        .remainder (mc_remainder)
    );

    result_select u_result (
        .clk        (clk),
        .resetn     (resetn),
        .alu_op     (exe_alu_op),
        .alu_result (alu_result),
        .product    (mc_product),
        .quotient   (mc_quotient),
        .remainder  (mc_remainder),
        .result     (final_result)
    );

    assign data_op   = is_store;
    assign data_addr = mem_addr;

    assign mem_result   = final_result;
    assign mem_rf_we    = exe_rf_we & ~misaligned;  // No writeback on ALE
    assign mem_rf_waddr = exe_rf_waddr;
    assign mem_pc       = exe_pc;
    assign mem_mem_op   = exe_mem_op;
    assign mem_ex_valid = misaligned;
    assign mem_ecode    = misaligned ? ecode_t'(`EXE_ECODE_ALE) : '0;
    assign mem_badv     = mem_addr;

endmodule

// File: verification/exe_stage_tb.sv
`timescale 1ns/1ns

module exe_stage_tb
    import exe_op_pkg::*;
();

    localparam int          MAX_TESTS   = 64;
    localparam int          STALL_LIMIT = 200;  // Cycles without a handoff
    localparam logic [31:0] PC_BASE     = 32'h1c00_0000;

    logic        clk;
    logic        resetn;
    logic        id_to_exe_valid;
    alu_op_e     id_alu_op;
    mem_op_e     id_mem_op;
    logic [31:0] id_src1;
    logic [31:0] id_src2;
    logic [31:0] id_rkd_value;
    logic        id_rf_we;
    logic [4:0]  id_rf_waddr;
    logic [31:0] id_pc;
    logic        mem_allowin;
    logic        data_addr_ok;
    logic        exe_allowin;
    logic        exe_to_mem_valid;
    logic [31:0] mem_result;
    logic        mem_rf_we;
    logic [4:0]  mem_rf_waddr;
    logic [31:0] mem_pc;
    mem_op_e     mem_mem_op;
    logic        mem_ex_valid;
    logic [5:0]  mem_ecode;
    logic [31:0] mem_badv;
    logic        data_valid;
    logic        data_op;
    logic [31:0] data_addr;
    logic [3:0]  data_wstrb;
    logic [31:0] data_wdata;

    // One row per golden line
    string       g_name   [MAX_TESTS];
    logic [4:0]  g_alu    [MAX_TESTS];
    logic [3:0]  g_mem    [MAX_TESTS];
    logic [31:0] g_src1   [MAX_TESTS];
    logic [31:0] g_src2   [MAX_TESTS];
    logic [31:0] g_rkd    [MAX_TESTS];
    logic [4:0]  g_dest   [MAX_TESTS];
    logic [31:0] g_result [MAX_TESTS];
    logic [3:0]  g_wstrb  [MAX_TESTS];
    logic [31:0] g_wdata  [MAX_TESTS];
    logic        g_exc    [MAX_TESTS];

    int          n_tests;
    int          in_idx;   // Next instruction to offer
    int          out_idx;  // Oldest instruction still in flight
    int          value_errors;
    int          protocol_errors;
    int          stall_cycles;
    logic        timed_out;
    logic        handed_off;
    logic [31:0] rnd_state;
    logic [63:0] cycle_cnt;

    exe_stage dut (
        .clk              (clk),
        .resetn           (resetn),
        .id_to_exe_valid  (id_to_exe_valid),
        .id_alu_op        (id_alu_op),
        .id_mem_op        (id_mem_op),
        .id_src1          (id_src1),
        .id_src2          (id_src2),
        .id_rkd_value     (id_rkd_value),
        .id_rf_we         (id_rf_we),
        .id_rf_waddr      (id_rf_waddr),
        .id_pc            (id_pc),
        .mem_allowin      (mem_allowin),
        .data_addr_ok     (data_addr_ok),
        .exe_allowin      (exe_allowin),
        .exe_to_mem_valid (exe_to_mem_valid),
        .mem_result       (mem_result),
        .mem_rf_we        (mem_rf_we),
        .mem_rf_waddr     (mem_rf_waddr),
        .mem_pc           (mem_pc),
        .mem_mem_op       (mem_mem_op),
        .mem_ex_valid     (mem_ex_valid),
        .mem_ecode        (mem_ecode),
        .mem_badv         (mem_badv),
        .data_valid       (data_valid),
        .data_op          (data_op),
        .data_addr        (data_addr),
        .data_wstrb       (data_wstrb),
        .data_wdata       (data_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Zero in the first cycle out of reset and one more per rising edge
    always @(posedge clk) begin
        if (!resetn) begin
            cycle_cnt <= 64'd0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_store_op(input logic [3:0] mop);
        return mop inside {ST_B, ST_H, ST_W};
    endfunction

    function automatic logic is_muldiv_op(input logic [4:0] op);
        return op inside {MUL, MULH, MULHU, DIV, MOD, DIVU, MODU};
    endfunction

    function automatic logic [31:0] pc_of(input int idx);
        return PC_BASE + 32'(idx) * 32'd4;
    endfunction

    task automatic report_protocol_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        protocol_errors++;
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: %s expected %08h actual %08h",
                     name, field, expected, actual);
            value_errors++;
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          code;
        int          fields;
        string       line;
        string       nm;
        logic [31:0] op;
        logic [31:0] mop;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] rkd;
        logic [31:0] dst;
        logic [31:0] res;
        logic [31:0] strb;
        logic [31:0] wd;
        logic [31:0] exc;
        n_tests = 0;
        fd = $fopen("verification/exe_golden.txt", "r");
        if (fd == 0) begin
            report_protocol_error("cannot open verification/exe_golden.txt");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin  // Skip # lines
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h",
                                     nm, op, mop, s1, s2, rkd, dst, res, strb, wd, exc);
                    if (fields == 11) begin
                        g_name[n_tests]   = nm;
                        g_alu[n_tests]    = op[4:0];
                        g_mem[n_tests]    = mop[3:0];
                        g_src1[n_tests]   = s1;
                        g_src2[n_tests]   = s2;
                        g_rkd[n_tests]    = rkd;
                        g_dest[n_tests]   = dst[4:0];
                        g_result[n_tests] = res;
                        g_wstrb[n_tests]  = strb[3:0];
                        g_wdata[n_tests]  = wd;
                        g_exc[n_tests]    = exc[0];
                        n_tests++;
                    end else begin
                        report_protocol_error({"malformed golden line: ", line});
                    end
                end
            end
            $fclose(fd);
        end
        if (n_tests == 0) begin
            report_protocol_error("golden file holds no instructions");
        end
    endtask

    task automatic drive_entry(input int idx);
        id_to_exe_valid = 1'b1;
        id_alu_op       = alu_op_e'(g_alu[idx]);
        id_mem_op       = mem_op_e'(g_mem[idx]);
        id_src1         = g_src1[idx];
        id_src2         = g_src2[idx];
        id_rkd_value    = g_rkd[idx];
        id_rf_we        = ~is_store_op(g_mem[idx]);  // Stores write no register
        id_rf_waddr     = g_dest[idx];
        id_pc           = pc_of(idx);
    endtask

    task automatic check_request(input int idx);
        if (g_mem[idx] == 4'd0 || g_exc[idx]) begin
            report_protocol_error({g_name[idx], " raised a data request it must not issue"});
        end
        compare_field(g_name[idx], "data_op", 32'(is_store_op(g_mem[idx])), 32'(data_op));
        compare_field(g_name[idx], "data_addr", g_src1[idx] + g_src2[idx], data_addr);
        compare_field(g_name[idx], "data_wstrb", 32'(g_wstrb[idx]), 32'(data_wstrb));
        compare_field(g_name[idx], "data_wdata", g_wdata[idx], data_wdata);
    endtask

    task automatic check_handoff(input int idx);
        logic [31:0] exp_result;
        logic [31:0] exp_ecode;
        logic        exp_we;
        exp_we    = ~is_store_op(g_mem[idx]) & ~g_exc[idx];
        exp_ecode = g_exc[idx] ? 32'h9 : 32'h0;
        if (g_alu[idx] == RDCNTVL) begin
            exp_result = cycle_cnt[31:0];
        end else if (g_alu[idx] == RDCNTVH) begin
            exp_result = cycle_cnt[63:32];
        end else begin
            exp_result = g_result[idx];
        end
        compare_field(g_name[idx], "mem_result", exp_result, mem_result);
        compare_field(g_name[idx], "mem_rf_we", 32'(exp_we), 32'(mem_rf_we));
        compare_field(g_name[idx], "mem_rf_waddr", 32'(g_dest[idx]), 32'(mem_rf_waddr));
        compare_field(g_name[idx], "mem_pc", pc_of(idx), mem_pc);
        compare_field(g_name[idx], "mem_mem_op", 32'(g_mem[idx]), 32'(mem_mem_op));
        compare_field(g_name[idx], "mem_ex_valid", 32'(g_exc[idx]), 32'(mem_ex_valid));
        compare_field(g_name[idx], "mem_ecode", exp_ecode, 32'(mem_ecode));
        if (g_exc[idx]) begin
            compare_field(g_name[idx], "mem_badv", g_src1[idx] + g_src2[idx], mem_badv);
        end
        // Aligned accesses leave only together with an accepted request
        if (g_mem[idx] != 4'd0 && !g_exc[idx] && !(data_valid && data_addr_ok)) begin
            report_protocol_error({g_name[idx], " handed off without an accepted data request"});
        end
    endtask

    task automatic monitor_cycle();
        logic stage_full;
        stage_full = (in_idx > out_idx);
        handed_off = 1'b0;
        if (data_valid && !mem_allowin) begin
            report_protocol_error("data_valid high while mem_allowin is low");
        end
        if (stage_full && !mem_allowin && exe_allowin) begin
            report_protocol_error("exe_allowin high while the stage is held");
        end
        // ALU, counter and faulting accesses need no wait at all
        if (stage_full && !exe_to_mem_valid && !is_muldiv_op(g_alu[out_idx])
                && (g_mem[out_idx] == 4'd0 || g_exc[out_idx])) begin
            report_protocol_error({g_name[out_idx], " not offered to the memory stage at once"});
        end
        if (data_valid && data_addr_ok && !exe_to_mem_valid) begin
            report_protocol_error("data request accepted without a handoff");
        end
        if (data_valid) begin
            if (stage_full) begin
                check_request(out_idx);
            end else begin
                report_protocol_error("data request with an empty stage");
            end
        end
        if (exe_to_mem_valid && mem_allowin) begin
            if (stage_full) begin
                check_handoff(out_idx);
                out_idx++;
                handed_off = 1'b1;
            end else begin
                report_protocol_error("handoff with no instruction in the stage");
            end
        end
    endtask

    initial begin
        resetn          = 1'b0;
        id_to_exe_valid = 1'b0;
        id_alu_op       = ADD;
        id_mem_op       = MEM_NONE;
        id_src1         = 32'd0;
        id_src2         = 32'd0;
        id_rkd_value    = 32'd0;
        id_rf_we        = 1'b0;
        id_rf_waddr     = 5'd0;
        id_pc           = 32'd0;
        mem_allowin     = 1'b0;
        data_addr_ok    = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        in_idx          = 0;
        out_idx         = 0;
        stall_cycles    = 0;
        timed_out       = 1'b0;
        handed_off      = 1'b0;
        rnd_state       = 32'h1b5c_950d;
        load_golden();

        repeat (2) @(negedge clk);  // Two rising edges in reset
        resetn = 1'b1;

        while (out_idx < n_tests && !timed_out) begin
            @(negedge clk);
            rnd_state    = lcg_next(rnd_state);
            mem_allowin  = (rnd_state[31:30] != 2'b00);
            data_addr_ok = (rnd_state[29:28] != 2'b00);
            if (in_idx < n_tests && rnd_state[27:26] != 2'b00) begin
                drive_entry(in_idx);
            end else begin
                id_to_exe_valid = 1'b0;  // Decode bubble
            end
            #1;
            monitor_cycle();
            if (id_to_exe_valid && exe_allowin) begin
                in_idx++;
            end
            if (handed_off) begin
                stall_cycles = 0;
            end else begin
                stall_cycles++;
                if (stall_cycles > STALL_LIMIT) begin
                    report_protocol_error($sformatf("timeout, instruction %0d never handed off",
                                                    out_idx));
                    timed_out = 1'b1;
                end
            end
        end

        // Nothing else may leave the stage in the idle tail
        if (!timed_out) begin
            repeat (4) begin
                @(negedge clk);
                id_to_exe_valid = 1'b0;
                mem_allowin     = 1'b1;
                data_addr_ok    = 1'b1;
                #1;
                monitor_cycle();
            end
        end

        $display("Summary: %0d value errors, %0d protocol errors, %0d of %0d handed off",
                 value_errors, protocol_errors, out_idx, n_tests);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+logic
logic/exe_op_pkg.sv
logic/exe_data_pkg.sv
logic/mem_access_decode.sv
logic/exe_alu.sv
logic/muldiv_unit.sv
logic/result_select.sv
logic/exe_stage.sv
verification/exe_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
bin=exe_stage_sim

verilator --binary --timing -Wno-fatal --top-module exe_stage_tb -f all.f -o "$bin"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$bin" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$log"; then
    exit 1
fi
exit 0

// File: verification/exe_golden.txt
# name alu_op mem_op src1 src2 rkd dest result wstrb wdata exc (all hex except name)
# rdcnt rows leave result at zero, the expected count comes from the testbench clock
add_basic     00 0 00000005 00000007 00000000 01 0000000c 0 00000000 0
add_wrap      00 0 ffffffff 00000001 00000000 02 00000000 0 00000000 0
sub_neg       01 0 00000003 00000005 00000000 03 fffffffe 0 00000000 0
slt_signed    02 0 ffffffff 00000001 00000000 04 00000001 0 00000000 0
sltu_unsigned 03 0 ffffffff 00000001 00000000 05 00000000 0 00000000 0
and_mask      04 0 f0f0f0f0 0ff00ff0 00000000 06 00f000f0 0 00000000 0
or_bits       05 0 12340000 00005678 00000000 07 12345678 0 00000000 0
nor_zero      06 0 00000000 00000000 00000000 08 ffffffff 0 00000000 0
xor_flip      07 0 aaaa5555 ffff0000 00000000 09 55555555 0 00000000 0
sll_mask      08 0 00000001 00000024 00000000 0a 00000010 0 00000000 0
srl_logic     09 0 80000000 0000001f 00000000 0b 00000001 0 00000000 0
sra_arith     0a 0 80000000 00000004 00000000 0c f8000000 0 00000000 0
lui_imm       0b 0 00000000 abcde000 00000000 0d abcde000 0 00000000 0
mul_neg       0c 0 fffffffd 00000007 00000000 0e ffffffeb 0 00000000 0
mulh_neg      0d 0 fffffffd 00000007 00000000 0f ffffffff 0 00000000 0
mulh_pos      0d 0 7fffffff 7fffffff 00000000 10 3fffffff 0 00000000 0
mulhu_big     0e 0 ffffffff ffffffff 00000000 11 fffffffe 0 00000000 0
div_neg       0f 0 fffffff9 00000002 00000000 12 fffffffd 0 00000000 0
mod_neg       10 0 fffffff9 00000002 00000000 13 ffffffff 0 00000000 0
div_signs     0f 0 ffffff9c fffffff9 00000000 14 0000000e 0 00000000 0
mod_signs     10 0 ffffff9c fffffff9 00000000 15 fffffffe 0 00000000 0
divu_basic    11 0 00000064 00000007 00000000 16 0000000e 0 00000000 0
modu_basic    12 0 00000064 00000007 00000000 17 00000002 0 00000000 0
div_zero      0f 0 00000011 00000000 00000000 18 ffffffff 0 00000000 0
mod_zero      10 0 00000011 00000000 00000000 19 00000011 0 00000000 0
divu_zero     11 0 12345678 00000000 00000000 1a ffffffff 0 00000000 0
modu_zero     12 0 12345678 00000000 00000000 1b 12345678 0 00000000 0
rdcnt_low     13 0 00000000 00000000 00000000 1c 00000000 0 00000000 0
rdcnt_high    14 0 00000000 00000000 00000000 1d 00000000 0 00000000 0
st_b_lane1    00 6 00001000 00000001 000000a5 00 00001001 2 0000a500 0
st_b_lane3    00 6 00001000 00000003 12345678 00 00001003 8 78000000 0
st_h_upper    00 7 00001000 00000002 0000beef 00 00001002 c beef0000 0
st_h_lower    00 7 00001000 00000004 ffffbeef 00 00001004 3 0000beef 0
st_w_word     00 8 00002000 00000004 cafef00d 00 00002004 f cafef00d 0
ld_w_word     00 3 00003000 00000008 00000000 1e 00003008 0 00000000 0
ld_bu_byte    00 4 00003000 00000001 00000000 1f 00003001 0 00000000 0
ld_hu_half    00 5 00004000 00000006 00000000 01 00004006 0 00000000 0
ld_h_ale      00 2 00003000 00000001 00000000 02 00003001 0 00000000 1
ld_w_ale      00 3 00003000 00000002 00000000 03 00003002 0 00000000 1
st_h_ale      00 7 00004000 00000001 00001234 00 00004001 0 00000000 1
st_w_ale      00 8 00004000 00000003 00001234 00 00004003 0 00000000 1
add_after     00 0 00000010 00000020 00000000 04 00000030 0 00000000 0
mul_tail      0c 0 00000006 00000007 00000000 05 0000002a 0 00000000 0
rdcnt_tail    13 0 00000000 00000000 00000000 06 00000000 0 00000000 0
